//--- Makefile
VERILATOR ?= verilator
TOP ?= aluPeripheralTb
FLAGS ?= --binary --timing --assert

SOURCES := $(wildcard logic/*.sv) $(wildcard verification/*.sv)
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): project.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f project.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

//--- logic/aluPeripheral.sv
`default_nettype none

module aluPeripheral (
	input wire logic clk,
	input wire logic reset,
	input wire logic awvalid,
	input wire aluPkg::regAddr awaddr,
	output logic awready,
	input wire logic wvalid,
	input wire aluPkg::dataWord wdata,
	output logic wready,
	output logic bvalid,
	input wire logic bready,
	output aluPkg::axiResp bresp,
	input wire logic arvalid,
	input wire aluPkg::regAddr araddr,
	output logic arready,
	output logic rvalid,
	input wire logic rready,
	output aluPkg::dataWord rdata,
	output aluPkg::axiResp rresp
);
	import aluPkg::*;

	dataWord result;
	logic illegal;

	operandIf opsBus ();
	decodedIf decBus ();

	axiLiteWriteSide u_writeSide (
		.clk, .reset,
		.awvalid, .awaddr, .awready,
		.wvalid, .wdata, .wready,
		.bvalid, .bready, .bresp,
		.ops(opsBus.source)
	);

	instructionDecoder u_decoder (
		.ops(opsBus.sink),
		.dec(decBus.source)
	);

	mipsAlu u_alu (
		.clk, .reset,
		.dec(decBus.sink),
		.result, .illegal
	);

	axiLiteReadSide u_readSide (
		.clk, .reset,
		.arvalid, .araddr, .arready,
		.rvalid, .rready, .rdata, .rresp,
		.result, .illegal, // Latched on the same edge BVALID rises
		.ops(opsBus.sink)
	);

endmodule

`default_nettype wire

//--- logic/aluPkg.sv
`default_nettype none

package aluPkg;

	typedef logic [31:0] dataWord;
	typedef logic [31:0] instrWord;
	typedef logic [4:0] regAddr; // Byte address inside the block
	typedef logic [4:0] shiftAmount;
	typedef logic [1:0] axiResp;

	typedef enum logic [3:0] {
		opAdd, opSub, opSlt, opSltu, opAnd, opOr, opXor,
		opSll, opSra, opSrl,
		opNone // Illegal encoding
	} aluOp;

	localparam axiResp respOkay = 2'b00;
	localparam axiResp respSlvErr = 2'b10;

	localparam regAddr addrInstruction = 5'h00;
	localparam regAddr addrOperandA = 5'h04;
	localparam regAddr addrOperandB = 5'h08;
	localparam regAddr addrResult = 5'h0C; // Read only
	localparam regAddr addrStatus = 5'h10; // Read only, bit 0 illegal

	localparam logic [5:0] opcSpecial = 6'b000000;
	localparam logic [5:0] opcAddiu = 6'b001000;
	localparam logic [5:0] opcSlti = 6'b001010;
	localparam logic [5:0] opcSltiu = 6'b001011;
	localparam logic [5:0] opcAndi = 6'b001100;
	localparam logic [5:0] opcOri = 6'b001101;
	localparam logic [5:0] opcXori = 6'b001110;
	localparam logic [5:0] opcLb = 6'b100000;
	localparam logic [5:0] opcLw = 6'b100011;
	localparam logic [5:0] opcLbu = 6'b100100;
	localparam logic [5:0] opcSb = 6'b101000;
	localparam logic [5:0] opcSw = 6'b101011;

	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnSrl = 6'b000010;
	localparam logic [5:0] fnSra = 6'b000011;
	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSrlv = 6'b000110;
	localparam logic [5:0] fnSrav = 6'b000111;
	localparam logic [5:0] fnAddu = 6'b100000;
	localparam logic [5:0] fnSubu = 6'b100010;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b101000; // Team encoding, not the MIPS32 one
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

endpackage

`default_nettype wire

//--- logic/axiLiteReadSide.sv
`default_nettype none

module axiLiteReadSide (
	input wire logic clk,
	input wire logic reset,
	input wire logic arvalid,
	input wire aluPkg::regAddr araddr,
	output logic arready,
	output logic rvalid,
	input wire logic rready,
	output aluPkg::dataWord rdata,
	output aluPkg::axiResp rresp,
	input wire aluPkg::dataWord result,
	input wire logic illegal,
	operandIf.sink ops
);
	import aluPkg::*;

	logic arFire;
	dataWord muxData;
	axiResp muxResp;

	assign arready = !rvalid; // One read in flight
	assign arFire = arvalid && arready;

	always_comb begin
		muxResp = respOkay;
		case (araddr)
			addrInstruction: muxData = ops.instruction;
			addrOperandA: muxData = ops.operandA;
			addrOperandB: muxData = ops.operandB;
			addrResult: muxData = result;
			addrStatus: muxData = {31'b0, illegal};
			default: begin
				muxData = '0;
				muxResp = respSlvErr;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (arFire) begin
			rdata <= muxData;
			rresp <= muxResp;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) rvalid <= 1'b0;
		else if (arFire) rvalid <= 1'b1;
		else if (rready) rvalid <= 1'b0;
	end

	rHold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

//--- logic/axiLiteWriteSide.sv
`default_nettype none

module axiLiteWriteSide (
	input wire logic clk,
	input wire logic reset,
	input wire logic awvalid,
	input wire aluPkg::regAddr awaddr,
	output logic awready,
	input wire logic wvalid,
	input wire aluPkg::dataWord wdata,
	output logic wready,
	output logic bvalid,
	input wire logic bready,
	output aluPkg::axiResp bresp,
	operandIf.source ops
);
	import aluPkg::*;

	logic awHeld;
	logic wHeld;
	regAddr addrHeld;
	dataWord dataHeld;
	logic respPending; // Register written, B goes out next edge
	logic awFire;
	logic wFire;
	logic commit;
	logic writable;
	regAddr curAddr;
	dataWord curData;
	instrWord instrReg;
	dataWord operandAReg;
	dataWord operandBReg;
	logic updatePulse;

	// Closed while a response is pending or waiting on BREADY
	assign awready = !awHeld && !bvalid && !respPending;
	assign wready = !wHeld && !bvalid && !respPending;
	assign awFire = awvalid && awready;
	assign wFire = wvalid && wready;

	assign curAddr = awHeld ? addrHeld : awaddr;
	assign curData = wHeld ? dataHeld : wdata;
	assign commit = (awHeld || awFire) && (wHeld || wFire); // Both beats in hand
	assign writable = curAddr inside {addrInstruction, addrOperandA, addrOperandB};

	always_ff @(posedge clk) begin
		if (awFire) addrHeld <= awaddr;
		if (wFire) dataHeld <= wdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			awHeld <= 1'b0;
			wHeld <= 1'b0;
			respPending <= 1'b0;
			bvalid <= 1'b0;
			bresp <= respOkay;
			updatePulse <= 1'b0;
			instrReg <= '0;
			operandAReg <= '0;
			operandBReg <= '0;
		end else begin
			awHeld <= commit ? 1'b0 : (awHeld || awFire);
			wHeld <= commit ? 1'b0 : (wHeld || wFire);
			respPending <= commit;
			updatePulse <= commit && writable;
			if (commit) begin
				bresp <= writable ? respOkay : respSlvErr;
				if (curAddr == addrInstruction) instrReg <= curData;
				if (curAddr == addrOperandA) operandAReg <= curData;
				if (curAddr == addrOperandB) operandBReg <= curData;
			end
			if (respPending) bvalid <= 1'b1; // Same edge the ALU latches
			else if (bready) bvalid <= 1'b0;
		end
	end

	assign ops.instruction = instrReg;
	assign ops.operandA = operandAReg;
	assign ops.operandB = operandBReg;
	assign ops.update = updatePulse;

	bHold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

//--- logic/decodedIf.sv
`default_nettype none

interface decodedIf;
	import aluPkg::*;

	aluOp op;
	dataWord operandA; // Shift source for shift ops
	dataWord operandB;
	shiftAmount shamt;
	logic illegal;
	logic update;

	modport source (output op, operandA, operandB, shamt, illegal, update);
	modport sink (input op, operandA, operandB, shamt, illegal, update);

endinterface

`default_nettype wire

//--- logic/instructionDecoder.sv
`default_nettype none

module instructionDecoder (
	operandIf.sink ops,
	decodedIf.source dec
);
	import aluPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	shiftAmount fieldShamt;
	dataWord immSigned;
	dataWord immZero;
	aluOp op;
	dataWord secondOperand;
	logic varShift; // Shift count from operand A
	logic isShift;

	assign opcode = ops.instruction[31:26];
	assign funct = ops.instruction[5:0];
	assign fieldShamt = ops.instruction[10:6];
	assign immSigned = {{16{ops.instruction[15]}}, ops.instruction[15:0]};
	assign immZero = {16'b0, ops.instruction[15:0]};

	always_comb begin
		op = opNone;
		secondOperand = ops.operandB;
		varShift = 1'b0;
		case (opcode)
			opcSpecial: begin
				case (funct)
					fnAddu: op = opAdd;
					fnSubu: op = opSub;
					fnSlt: op = opSlt;
					fnSltu: op = opSltu;
					fnAnd: op = opAnd;
					fnOr: op = opOr;
					fnXor: op = opXor;
					fnSll: op = opSll;
					fnSra: op = opSra;
					fnSrl: op = opSrl;
					fnSllv: begin
						op = opSll;
						varShift = 1'b1;
					end
					fnSrav: begin
						op = opSra;
						varShift = 1'b1;
					end
					fnSrlv: begin
						op = opSrl;
						varShift = 1'b1;
					end
					default: op = opNone;
				endcase
			end
			opcAddiu, opcLw, opcSw, opcLb, opcLbu, opcSb: begin
				op = opAdd; // Plain add for address forms
				secondOperand = immSigned;
			end
			opcSlti: begin
				op = opSlt;
				secondOperand = immSigned;
			end
			opcSltiu: begin
				op = opSltu;
				secondOperand = immSigned; // Sign extended, compared unsigned
			end
			opcAndi: begin
				op = opAnd;
				secondOperand = immZero;
			end
			opcOri: begin
				op = opOr;
				secondOperand = immZero;
			end
			opcXori: begin
				op = opXor;
				secondOperand = immZero;
			end
			default: op = opNone;
		endcase
	end

	assign isShift = op inside {opSll, opSra, opSrl};

	assign dec.op = op;
	assign dec.illegal = (op == opNone);
	assign dec.operandA = isShift ? ops.operandB : ops.operandA; // rt is shifted
	assign dec.operandB = secondOperand;
	assign dec.shamt = varShift ? ops.operandA[4:0] : fieldShamt;
	assign dec.update = ops.update;

endmodule

`default_nettype wire

//--- logic/mipsAlu.sv
`default_nettype none

module mipsAlu (
	input wire logic clk,
	input wire logic reset,
	decodedIf.sink dec,
	output aluPkg::dataWord result,
	output logic illegal
);
	import aluPkg::*;

	dataWord nextResult;

	always_comb begin
		case (dec.op)
			opAdd: nextResult = dec.operandA + dec.operandB;
			opSub: nextResult = dec.operandA - dec.operandB;
			opSlt: nextResult = {31'b0, $signed(dec.operandA) < $signed(dec.operandB)};
			opSltu: nextResult = {31'b0, dec.operandA < dec.operandB};
			opAnd: nextResult = dec.operandA & dec.operandB;
			opOr: nextResult = dec.operandA | dec.operandB;
			opXor: nextResult = dec.operandA ^ dec.operandB;
			opSll: nextResult = dec.operandA << dec.shamt;
			opSra: nextResult = $signed(dec.operandA) >>> dec.shamt; // Keeps sign
			opSrl: nextResult = dec.operandA >> dec.shamt;
			default: nextResult = '0; // opNone
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			illegal <= 1'b0;
		end else if (dec.update) begin
			result <= nextResult;
			illegal <= dec.illegal;
		end
	end

	// Decoder output must be settled by the time the write side pulses update
	opKnown: assert property (@(posedge clk) disable iff (reset)
		dec.update |-> !$isunknown(dec.op));

endmodule

`default_nettype wire

//--- logic/operandIf.sv
`default_nettype none

interface operandIf;
	import aluPkg::*;

	instrWord instruction;
	dataWord operandA;
	dataWord operandB;
	logic update; // One cycle after a register write

	modport source (output instruction, operandA, operandB, update);
	modport sink (input instruction, operandA, operandB, update);

endinterface

`default_nettype wire

//--- project.f
logic/aluPkg.sv
logic/operandIf.sv
logic/decodedIf.sv
logic/axiLiteWriteSide.sv
logic/instructionDecoder.sv
logic/mipsAlu.sv
logic/axiLiteReadSide.sv
logic/aluPeripheral.sv
verification/aluPeripheralTb.sv

//--- verification/aluPeripheralTb.sv
`default_nettype none

module aluPeripheralTb;
	timeunit 1ns;
	timeprecision 100ps;
	import aluPkg::*;

	localparam int clkPeriod = 40;
	localparam int numRows = 28;
	localparam int rowBoundCycles = 100; // Eight bus transactions with stalls
	localparam int marginCycles = 300;
	localparam logic fixedOps = 1'b0;
	localparam logic lfsrOps = 1'b1;
	localparam logic byTable = 1'b0;
	localparam logic byModel = 1'b1;

	typedef struct packed {
		instrWord instr;
		logic randomOps;
		dataWord a;
		dataWord b;
		logic useModel;
		dataWord expResult;
		logic expIllegal;
	} testRow;

	logic clk = 1'b0;
	logic reset;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	regAddr awaddr, araddr;
	dataWord wdata, rdata;
	axiResp bresp, rresp;
	logic [15:0] lfsrState = 16'd4607;

	testRow testTable [numRows] = '{
		'{32'h0000_0020, fixedOps, 32'd5, 32'd7, byTable, 32'd12, 1'b0}, // ADDU
		'{32'h0000_0022, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0}, // SUBU
		'{32'h0000_002A, fixedOps, 32'hFFFF_FFFF, 32'd1, byTable, 32'd1, 1'b0}, // SLT signed
		'{32'h0000_002B, fixedOps, 32'hFFFF_FFFF, 32'd1, byTable, 32'd0, 1'b0}, // SLTU
		'{32'h0000_002A, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0},
		'{32'h0000_0024, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0}, // AND
		'{32'h0000_0025, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0}, // OR
		'{32'h0000_0028, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0}, // XOR
		'{32'h0000_0100, fixedOps, 32'd3, 32'h0000_000F, byTable, 32'h0000_00F0, 1'b0}, // SLL 4
		'{32'h0000_0203, fixedOps, 32'd0, 32'h8000_0000, byTable, 32'hFF80_0000, 1'b0}, // SRA 8
		'{32'h0000_0202, fixedOps, 32'd0, 32'h8000_0000, byTable, 32'h0080_0000, 1'b0}, // SRL 8
		'{32'h0000_0004, fixedOps, 32'd33, 32'd1, byTable, 32'd2, 1'b0}, // SLLV by 33 acts as 1
		'{32'h0000_0007, fixedOps, 32'd36, 32'hF000_0000, byTable, 32'hFF00_0000, 1'b0}, // SRAV
		'{32'h0000_0006, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0}, // SRLV
		'{32'h2000_FFFF, fixedOps, 32'd10, 32'd0, byTable, 32'd9, 1'b0}, // ADDIU -1
		'{32'h2800_FFFE, fixedOps, 32'd5, 32'd0, byTable, 32'd0, 1'b0}, // SLTI 5 < -2 is false
		'{32'h2C00_FFFF, fixedOps, 32'h0001_0000, 32'd0, byTable, 32'd1, 1'b0}, // SLTIU
		'{32'h3000_F0F0, fixedOps, 32'hFFFF_FFFF, 32'd0, byTable, 32'h0000_F0F0, 1'b0}, // ANDI
		'{32'h3400_8000, fixedOps, 32'h1234_0000, 32'd0, byTable, 32'h1234_8000, 1'b0}, // ORI
		'{32'h3800_FFFF, fixedOps, 32'hFFFF_0000, 32'd0, byTable, 32'hFFFF_FFFF, 1'b0}, // XORI
		'{32'h8C00_FFFC, fixedOps, 32'h0000_0100, 32'd0, byTable, 32'h0000_00FC, 1'b0}, // LW
		'{32'hAC00_0010, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0}, // SW
		'{32'h8000_8000, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0}, // LB
		'{32'h9000_0004, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0}, // LBU
		'{32'hA000_FFFF, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0}, // SB
		'{32'hFC00_0000, fixedOps, 32'd1, 32'd2, byTable, 32'd0, 1'b1}, // Unknown opcode
		'{32'h0000_0018, lfsrOps, 32'd0, 32'd0, byTable, 32'd0, 1'b1}, // MULT not supported
		'{32'h0000_0020, lfsrOps, 32'd0, 32'd0, byModel, 32'd0, 1'b0} // Clears the flag
	};

	aluPeripheral u_dut (.*);

	always #(clkPeriod / 2) clk = ~clk;

	task automatic failRun();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input dataWord expected, input dataWord actual);
		assert (actual === expected) else begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			failRun();
		end
	endtask

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic dataWord drawBits(input int count);
		dataWord bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic void modelAlu(input instrWord instr, input dataWord a, input dataWord b,
			output dataWord res, output logic ill);
		dataWord se;
		dataWord ze;
		se = {{16{instr[15]}}, instr[15:0]};
		ze = {16'h0000, instr[15:0]};
		res = '0;
		ill = 1'b0;
		if (instr[31:26] == opcSpecial) begin
			case (instr[5:0])
				fnAddu: res = a + b;
				fnSubu: res = a - b;
				fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				fnSltu: res = (a < b) ? 32'd1 : 32'd0;
				fnAnd: res = a & b;
				fnOr: res = a | b;
				fnXor: res = a ^ b;
				fnSll: res = b << instr[10:6]; // rt is the shifted word
				fnSrl: res = b >> instr[10:6];
				fnSra: res = $signed(b) >>> instr[10:6];
				fnSllv: res = b << a[4:0];
				fnSrlv: res = b >> a[4:0];
				fnSrav: res = $signed(b) >>> a[4:0];
				default: ill = 1'b1;
			endcase
		end else begin
			case (instr[31:26])
				opcAddiu, opcLw, opcSw, opcLb, opcLbu, opcSb: res = a + se;
				opcSlti: res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
				opcSltiu: res = (a < se) ? 32'd1 : 32'd0;
				opcAndi: res = a & ze;
				opcOri: res = a | ze;
				opcXori: res = a ^ ze;
				default: ill = 1'b1;
			endcase
		end
	endfunction

	// Starts and ends 2 ns after a rising edge
	task automatic axiWrite(input regAddr addr, input dataWord data, input axiResp expResp);
		logic awDone;
		logic wDone;
		int stall;
		axiResp firstResp;
		awDone = 1'b0;
		wDone = 1'b0;
		stall = drawBits(2);
		awvalid = 1'b1;
		awaddr = addr;
		wvalid = 1'b1;
		wdata = data;
		while (!(awDone && wDone)) begin
			@(negedge clk);
			if (awvalid && awready) awDone = 1'b1;
			if (wvalid && wready) wDone = 1'b1;
			@(posedge clk);
			#2;
			if (awDone) awvalid = 1'b0;
			if (wDone) wvalid = 1'b0;
		end
		do @(negedge clk); while (!bvalid);
		firstResp = bresp;
		repeat (stall) begin
			@(negedge clk);
			checkEq("bvalid", 32'd1, 32'(bvalid));
			checkEq("bresp", 32'(firstResp), 32'(bresp));
			checkEq("awready", 32'd0, 32'(awready)); // Next write held off
			checkEq("wready", 32'd0, 32'(wready));
		end
		@(posedge clk);
		#2;
		bready = 1'b1;
		do @(negedge clk); while (!(bvalid && bready));
		checkEq("bresp", 32'(expResp), 32'(bresp));
		@(posedge clk);
		#2;
		bready = 1'b0;
	endtask

	task automatic axiRead(input regAddr addr, input axiResp expResp, output dataWord data);
		int stall;
		dataWord firstData;
		stall = drawBits(2);
		arvalid = 1'b1;
		araddr = addr;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		#2;
		arvalid = 1'b0;
		do @(negedge clk); while (!rvalid);
		firstData = rdata;
		repeat (stall) begin
			@(negedge clk);
			checkEq("rvalid", 32'd1, 32'(rvalid));
			checkEq("rdata", firstData, rdata);
		end
		@(posedge clk);
		#2;
		rready = 1'b1;
		do @(negedge clk); while (!(rvalid && rready));
		checkEq("rresp", 32'(expResp), 32'(rresp));
		data = rdata;
		@(posedge clk);
		#2;
		rready = 1'b0;
	endtask

	initial begin
		#((numRows * rowBoundCycles + marginCycles) * clkPeriod);
		$display("Timeout: the testbench did not finish within the expected time");
		failRun();
	end

	initial begin
		testRow row;
		dataWord a;
		dataWord b;
		dataWord expRes;
		logic expIll;
		dataWord got;
		reset = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		checkEq("bvalid", 32'd0, 32'(bvalid));
		checkEq("rvalid", 32'd0, 32'(rvalid));
		checkEq("awready", 32'd1, 32'(awready));
		checkEq("wready", 32'd1, 32'(wready));
		checkEq("arready", 32'd1, 32'(arready));
		@(posedge clk);
		#2;
		foreach (testTable[i]) begin
			row = testTable[i];
			a = row.randomOps ? drawBits(32) : row.a;
			b = row.randomOps ? drawBits(32) : row.b;
			if (row.useModel) begin
				modelAlu(row.instr, a, b, expRes, expIll);
			end else begin
				expRes = row.expResult;
				expIll = row.expIllegal;
			end
			axiWrite(addrInstruction, row.instr, respOkay);
			axiWrite(addrOperandA, a, respOkay);
			axiWrite(addrOperandB, b, respOkay);
			axiRead(addrResult, respOkay, got);
			checkEq("result", expRes, got);
			axiRead(addrStatus, respOkay, got);
			checkEq("status", {31'b0, expIll}, got);
			axiRead(addrInstruction, respOkay, got);
			checkEq("instruction", row.instr, got);
			axiRead(addrOperandA, respOkay, got);
			checkEq("operandA", a, got);
			axiRead(addrOperandB, respOkay, got);
			checkEq("operandB", b, got);
		end
		// Read-only and unmapped writes must leave everything as it was
		axiWrite(addrResult, 32'hDEAD_BEEF, respSlvErr);
		axiWrite(addrStatus, 32'h0000_0001, respSlvErr);
		axiWrite(5'h14, 32'h1234_5678, respSlvErr);
		axiRead(addrResult, respOkay, got);
		checkEq("result", expRes, got);
		axiRead(addrStatus, respOkay, got);
		checkEq("status", {31'b0, expIll}, got);
		axiRead(addrInstruction, respOkay, got);
		checkEq("instruction", row.instr, got);
		axiRead(addrOperandA, respOkay, got);
		checkEq("operandA", a, got);
		axiRead(addrOperandB, respOkay, got);
		checkEq("operandB", b, got);
		axiRead(5'h18, respSlvErr, got);
		checkEq("rdata", 32'd0, got);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
